/* bm_pkg.sv */
package bm_pkg;

    // ----------------------------------------
    // shape widths
    // ----------------------------------------
    localparam int SIZE_W   = 8;
    localparam int CHN_W    = 8;
    // width x channel product
    localparam int STRIDE_W = SIZE_W + CHN_W;

    // word widths
    localparam int IFM_DW    = 32;
    // nine 8-bit taps per filter word
    localparam int FILTER_DW = 72;

    // ----------------------------------------
    // storage sizes
    // ----------------------------------------
    // whole input feature map
    localparam int IFM_DEPTH    = 65536;
    localparam int IFM_AW       = 16;
    // one row of width x channel words
    localparam int ROW_DEPTH    = 1536;
    localparam int ROW_AW       = 11;
    // per filter bank
    localparam int FILTER_DEPTH = 512;
    localparam int FILTER_AW    = 9;
    localparam int NUM_FB       = 4;

    // control pipe depth, output register adds the third cycle
    localparam int CTRL_DELAY = 2;

    typedef logic [IFM_DW-1:0]    ifm_word_t;
    typedef logic [FILTER_DW-1:0] filter_word_t;

    // role of a row buffer inside the 3-row window
    typedef enum logic [1:0] {
        ROLE_ABV = 2'd0,
        ROLE_CUR = 2'd1,
        ROLE_BEL = 2'd2
    } row_role_e;

endpackage

/* dpram.sv */
`timescale 1ns/10ps

module dpram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 512,
    parameter int  AW     = 9
) (
    input  logic          clk,
    // write port
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  word_t         wr_data,
    // read port
    input  logic          rd_en,
    input  logic [AW-1:0] rd_addr,
    output word_t         rd_data
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency, output holds while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* filter_bank.sv */
`timescale 1ns/10ps

module filter_bank (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          csync_start,
    input  logic [bm_pkg::CHN_W-1:0]      q_channel,
    // load port
    input  logic                          fb_wr_en,
    input  logic [1:0]                    fb_wr_bank,
    input  logic [bm_pkg::FILTER_AW-1:0]  fb_wr_addr,
    input  bm_pkg::filter_word_t          fb_wr_data,
    // engine read port
    input  logic                          fb_req,
    input  logic [bm_pkg::FILTER_AW-1:0]  fb_addr,
    output bm_pkg::filter_word_t          fb_data0,
    output bm_pkg::filter_word_t          fb_data1,
    output bm_pkg::filter_word_t          fb_data2,
    output bm_pkg::filter_word_t          fb_data3,
    output logic                          fb_ready
);
    import bm_pkg::*;

    logic         bank_we [NUM_FB];
    filter_word_t bank_rd [NUM_FB];
    logic [FILTER_AW-1:0] last_addr;
    logic                 last_write;

    // ----------------------------------------
    // four banks, shared read address
    // ----------------------------------------
    for (genvar b = 0; b < NUM_FB; b++) begin : g_bank
        // bank select decode
        assign bank_we[b] = fb_wr_en && (fb_wr_bank == 2'(b));

        dpram #(
            .word_t (filter_word_t),
            .DEPTH  (FILTER_DEPTH),
            .AW     (FILTER_AW)
        ) u_filter_ram (
            .clk     (clk),
            .wr_en   (bank_we[b]),
            .wr_addr (fb_wr_addr),
            .wr_data (fb_wr_data),
            .rd_en   (fb_req),
            .rd_addr (fb_addr),
            .rd_data (bank_rd[b])
        );
    end

    assign fb_data0 = bank_rd[0];
    assign fb_data1 = bank_rd[1];
    assign fb_data2 = bank_rd[2];
    assign fb_data3 = bank_rd[3];

    // ----------------------------------------
    // ready flag
    // ----------------------------------------
    // bank 3 is loaded last, its top word is 4 x channels - 1
    assign last_addr  = FILTER_AW'({q_channel, 2'b00}) - 1'b1;
    assign last_write = bank_we[3] && (fb_wr_addr == last_addr);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fb_ready <= 1'b0;
        end else if (csync_start) begin
            // new sync, filters must be reloaded
            fb_ready <= 1'b0;
        end else if (last_write) begin
            fb_ready <= 1'b1;
        end
    end

endmodule

/* row_prefill.sv */
`timescale 1ns/10ps

module row_prefill (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         csync_start,
    input  logic                         c_csync_run,
    input  logic [bm_pkg::STRIDE_W-1:0]  row_stride,
    output logic                         pf_run,
    output logic                         pf_vld,
    output logic [bm_pkg::ROW_AW-1:0]    pf_addr,
    output logic [bm_pkg::ROW_AW-1:0]    pf_addr_d,
    output logic                         pf_done
);
    import bm_pkg::*;

    logic [ROW_AW-1:0] last_addr;

    // words per row minus one
    assign last_addr = row_stride[ROW_AW-1:0] - 1'b1;

    // ----------------------------------------
    // row 0 copy, one word per cycle
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pf_run  <= 1'b0;
            pf_done <= 1'b0;
            pf_addr <= '0;
        end else if (csync_start) begin
            pf_run  <= 1'b1;
            pf_done <= 1'b0;
            pf_addr <= '0;
        end else if (pf_run) begin
            pf_addr <= pf_addr + 1'b1;
            // last read issued this cycle
            if (pf_addr == last_addr) begin
                pf_run  <= 1'b0;
                pf_done <= 1'b1;
            end
        end else if (!c_csync_run) begin
            // sync over
            pf_done <= 1'b0;
        end
    end

    // aligned with the feature-map read latency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pf_vld    <= 1'b0;
            pf_addr_d <= '0;
        end else begin
            pf_vld    <= pf_run;
            pf_addr_d <= pf_addr;
        end
    end

endmodule

/* ifm_addr_gen.sv */
`timescale 1ns/10ps

module ifm_addr_gen (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         csync_start,
    input  logic [bm_pkg::SIZE_W-1:0]    q_width,
    input  logic [bm_pkg::CHN_W-1:0]     q_channel,
    // controller coordinate
    input  logic                         c_data_run,
    input  logic [bm_pkg::SIZE_W-1:0]    c_col,
    input  logic [bm_pkg::CHN_W-1:0]     c_chn,
    input  logic                         c_is_last_row,
    input  logic                         c_is_last_col,
    input  logic                         c_is_last_chn,
    // prefill
    input  logic                         pf_run,
    input  logic [bm_pkg::ROW_AW-1:0]    pf_addr,
    // stage 0 of the control pipe
    input  logic                         data_run_s0,
    input  logic                         c_is_last_row_s0,
    output logic [bm_pkg::STRIDE_W-1:0]  row_stride,
    output logic                         ifm_rd_en,
    output logic [bm_pkg::IFM_AW-1:0]    ifm_rd_addr,
    output logic [bm_pkg::ROW_AW-1:0]    row_rd_addr,
    output logic [bm_pkg::ROW_AW-1:0]    row_wr_addr
);
    import bm_pkg::*;

    logic [STRIDE_W-1:0] offset;
    logic [IFM_AW-1:0]   row_base;
    logic [IFM_AW-1:0]   ifm_addr_q;
    logic [ROW_AW-1:0]   row_addr_q;
    logic [ROW_AW-1:0]   row_addr_d;
    logic                row_end;

    // words per row and word position inside the row
    assign row_stride = q_width * q_channel;
    assign offset     = c_col * q_channel + STRIDE_W'(c_chn);
    assign row_end    = c_is_last_col && c_is_last_chn;

    // ----------------------------------------
    // stage 1 address registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_base   <= '0;
            ifm_addr_q <= '0;
            row_addr_q <= '0;
        end else if (csync_start) begin
            row_base   <= '0;
            ifm_addr_q <= '0;
            row_addr_q <= '0;
        end else if (c_data_run) begin
            row_addr_q <= offset[ROW_AW-1:0];
            // fetch the row below the current one
            ifm_addr_q <= row_base + offset + row_stride;
            if (row_end && !c_is_last_row) begin
                row_base <= row_base + row_stride;
            end
        end
    end

    // write offset trails the read by the ram latency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_addr_d <= '0;
        end else if (csync_start) begin
            row_addr_d <= '0;
        end else begin
            row_addr_d <= row_addr_q;
        end
    end

    // no row below on the last row
    assign ifm_rd_en   = pf_run || (data_run_s0 && !c_is_last_row_s0);
    assign ifm_rd_addr = pf_run ? IFM_AW'(pf_addr) : ifm_addr_q;
    assign row_rd_addr = row_addr_q;
    assign row_wr_addr = row_addr_d;

endmodule

/* row_window.sv */
`timescale 1ns/10ps

module row_window (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       csync_start,
    input  logic                       c_data_run,
    input  logic                       c_is_first_row,
    input  logic                       c_is_last_row,
    input  logic                       c_is_last_col,
    input  logic                       c_is_last_chn,
    // prefill write
    input  logic                       pf_vld,
    input  logic [bm_pkg::ROW_AW-1:0]  pf_addr_d,
    // data run offsets
    input  logic [bm_pkg::ROW_AW-1:0]  row_rd_addr,
    input  logic [bm_pkg::ROW_AW-1:0]  row_wr_addr,
    input  bm_pkg::ifm_word_t          ifm_rd_data,
    output logic                       data_run_s0,
    output logic                       c_is_last_row_s0,
    output bm_pkg::ifm_word_t          ib_data0,
    output bm_pkg::ifm_word_t          ib_data1,
    output bm_pkg::ifm_word_t          ib_data2
);
    import bm_pkg::*;

    // packed as {last_chn, last_col, last_row, first_row, run}
    logic [4:0] ctrl_pipe [CTRL_DELAY];
    logic       run_d;
    logic       first_row_d;
    logic       last_row_d;
    logic       last_col_d;
    logic       last_chn_d;

    row_role_e         role     [3];
    logic              row_we   [3];
    logic [ROW_AW-1:0] row_wa   [3];
    ifm_word_t         row_dout [3];
    ifm_word_t         abv_word;
    ifm_word_t         cur_word;

    // ----------------------------------------
    // control delay pipe
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < CTRL_DELAY; i++) begin
                ctrl_pipe[i] <= '0;
            end
        end else begin
            ctrl_pipe[0] <= {c_is_last_chn, c_is_last_col, c_is_last_row,
                             c_is_first_row, c_data_run};
            for (int i = 1; i < CTRL_DELAY; i++) begin
                ctrl_pipe[i] <= ctrl_pipe[i-1];
            end
        end
    end

    // stage 0 drives the ram read enables
    assign data_run_s0      = ctrl_pipe[0][0];
    assign c_is_last_row_s0 = ctrl_pipe[0][2];
    assign {last_chn_d, last_col_d, last_row_d, first_row_d, run_d} = ctrl_pipe[CTRL_DELAY-1];

    // ----------------------------------------
    // role rotation at row end
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            role[0] <= ROLE_CUR;
            role[1] <= ROLE_BEL;
            role[2] <= ROLE_ABV;
        end else if (csync_start) begin
            // prefilled buffer 0 becomes the current row
            role[0] <= ROLE_CUR;
            role[1] <= ROLE_BEL;
            role[2] <= ROLE_ABV;
        end else if (run_d && last_col_d && last_chn_d) begin
            // cur -> abv, bel -> cur, abv freed for the next row below
            role[0] <= role[2];
            role[1] <= role[0];
            role[2] <= role[1];
        end
    end

    // ----------------------------------------
    // three row rams
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            row_we[i] = run_d && (role[i] == ROLE_BEL);
            row_wa[i] = row_wr_addr;
        end
        // prefill lands in buffer 0 only
        row_we[0] = row_we[0] || pf_vld;
        row_wa[0] = pf_vld ? pf_addr_d : row_wr_addr;
    end

    for (genvar b = 0; b < 3; b++) begin : g_row
        dpram #(
            .word_t (ifm_word_t),
            .DEPTH  (ROW_DEPTH),
            .AW     (ROW_AW)
        ) u_row_ram (
            .clk     (clk),
            .wr_en   (row_we[b]),
            .wr_addr (row_wa[b]),
            .wr_data (ifm_rd_data),
            .rd_en   (data_run_s0),
            .rd_addr (row_rd_addr),
            .rd_data (row_dout[b])
        );
    end

    // role muxes
    always_comb begin
        abv_word = '0;
        cur_word = '0;
        for (int i = 0; i < 3; i++) begin
            if (role[i] == ROLE_ABV) abv_word = row_dout[i];
            if (role[i] == ROLE_CUR) cur_word = row_dout[i];
        end
    end

    // ----------------------------------------
    // output registers, zero padding at edges
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ib_data0 <= '0;
            ib_data1 <= '0;
            ib_data2 <= '0;
        end else if (!run_d) begin
            // idle slot
            ib_data0 <= '0;
            ib_data1 <= '0;
            ib_data2 <= '0;
        end else begin
            ib_data0 <= first_row_d ? '0 : abv_word;
            ib_data1 <= cur_word;
            // row below comes straight from the feature map
            ib_data2 <= last_row_d ? '0 : ifm_rd_data;
        end
    end

endmodule

/* buffer_manager.sv */
`timescale 1ns/10ps

module buffer_manager (
    input  logic                          clk,
    input  logic                          rstn,
    // feature-map load
    input  logic                          ib_wr_en,
    input  logic [bm_pkg::IFM_AW-1:0]     ib_wr_addr,
    input  bm_pkg::ifm_word_t             ib_wr_data,
    // filter load
    input  logic                          fb_wr_en,
    input  logic [1:0]                    fb_wr_bank,
    input  logic [bm_pkg::FILTER_AW-1:0]  fb_wr_addr,
    input  bm_pkg::filter_word_t          fb_wr_data,
    // layer shape
    input  logic [bm_pkg::SIZE_W-1:0]     q_width,
    input  logic [bm_pkg::CHN_W-1:0]      q_channel,
    // controller
    input  logic                          c_csync_run,
    input  logic                          c_data_run,
    input  logic [bm_pkg::SIZE_W-1:0]     c_row,
    input  logic [bm_pkg::SIZE_W-1:0]     c_col,
    input  logic [bm_pkg::CHN_W-1:0]      c_chn,
    input  logic                          c_is_first_row,
    input  logic                          c_is_last_row,
    input  logic                          c_is_last_col,
    input  logic                          c_is_last_chn,
    output logic                          csync_done,
    // engine side
    input  logic                          fb_req,
    input  logic [bm_pkg::FILTER_AW-1:0]  fb_addr,
    output logic                          fb_ready,
    output bm_pkg::ifm_word_t             ib_data0,
    output bm_pkg::ifm_word_t             ib_data1,
    output bm_pkg::ifm_word_t             ib_data2,
    output bm_pkg::filter_word_t          fb_data0,
    output bm_pkg::filter_word_t          fb_data1,
    output bm_pkg::filter_word_t          fb_data2,
    output bm_pkg::filter_word_t          fb_data3
);
    import bm_pkg::*;

    logic                csync_d;
    logic                csync_start;
    logic [STRIDE_W-1:0] row_stride;
    logic                pf_run;
    logic                pf_vld;
    logic                pf_done;
    logic [ROW_AW-1:0]   pf_addr;
    logic [ROW_AW-1:0]   pf_addr_d;
    logic                ifm_rd_en;
    logic [IFM_AW-1:0]   ifm_rd_addr;
    ifm_word_t           ifm_rd_data;
    logic [ROW_AW-1:0]   row_rd_addr;
    logic [ROW_AW-1:0]   row_wr_addr;
    logic                data_run_s0;
    logic                c_is_last_row_s0;

    // ----------------------------------------
    // csync rising edge
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            csync_d <= 1'b0;
        end else begin
            csync_d <= c_csync_run;
        end
    end

    assign csync_start = c_csync_run && !csync_d;

    // row 0 copied and filters loaded
    assign csync_done = c_csync_run && fb_ready && pf_done;

    // c_row kept for the engine interface, rows are tracked by row base
    // whole feature map store
    dpram #(
        .word_t (ifm_word_t),
        .DEPTH  (IFM_DEPTH),
        .AW     (IFM_AW)
    ) u_ifm_ram (
        .clk     (clk),
        .wr_en   (ib_wr_en),
        .wr_addr (ib_wr_addr),
        .wr_data (ib_wr_data),
        .rd_en   (ifm_rd_en),
        .rd_addr (ifm_rd_addr),
        .rd_data (ifm_rd_data)
    );

    filter_bank u_filter_bank (
        .clk         (clk),
        .rstn        (rstn),
        .csync_start (csync_start),
        .q_channel   (q_channel),
        .fb_wr_en    (fb_wr_en),
        .fb_wr_bank  (fb_wr_bank),
        .fb_wr_addr  (fb_wr_addr),
        .fb_wr_data  (fb_wr_data),
        .fb_req      (fb_req),
        .fb_addr     (fb_addr),
        .fb_data0    (fb_data0),
        .fb_data1    (fb_data1),
        .fb_data2    (fb_data2),
        .fb_data3    (fb_data3),
        .fb_ready    (fb_ready)
    );

    row_prefill u_row_prefill (
        .clk         (clk),
        .rstn        (rstn),
        .csync_start (csync_start),
        .c_csync_run (c_csync_run),
        .row_stride  (row_stride),
        .pf_run      (pf_run),
        .pf_vld      (pf_vld),
        .pf_addr     (pf_addr),
        .pf_addr_d   (pf_addr_d),
        .pf_done     (pf_done)
    );

    ifm_addr_gen u_ifm_addr_gen (
        .clk              (clk),
        .rstn             (rstn),
        .csync_start      (csync_start),
        .q_width          (q_width),
        .q_channel        (q_channel),
        .c_data_run       (c_data_run),
        .c_col            (c_col),
        .c_chn            (c_chn),
        .c_is_last_row    (c_is_last_row),
        .c_is_last_col    (c_is_last_col),
        .c_is_last_chn    (c_is_last_chn),
        .pf_run           (pf_run),
        .pf_addr          (pf_addr),
        .data_run_s0      (data_run_s0),
        .c_is_last_row_s0 (c_is_last_row_s0),
        .row_stride       (row_stride),
        .ifm_rd_en        (ifm_rd_en),
        .ifm_rd_addr      (ifm_rd_addr),
        .row_rd_addr      (row_rd_addr),
        .row_wr_addr      (row_wr_addr)
    );

    row_window u_row_window (
        .clk              (clk),
        .rstn             (rstn),
        .csync_start      (csync_start),
        .c_data_run       (c_data_run),
        .c_is_first_row   (c_is_first_row),
        .c_is_last_row    (c_is_last_row),
        .c_is_last_col    (c_is_last_col),
        .c_is_last_chn    (c_is_last_chn),
        .pf_vld           (pf_vld),
        .pf_addr_d        (pf_addr_d),
        .row_rd_addr      (row_rd_addr),
        .row_wr_addr      (row_wr_addr),
        .ifm_rd_data      (ifm_rd_data),
        .data_run_s0      (data_run_s0),
        .c_is_last_row_s0 (c_is_last_row_s0),
        .ib_data0         (ib_data0),
        .ib_data1         (ib_data1),
        .ib_data2         (ib_data2)
    );

endmodule

/* tb_buffer_manager.sv */
`timescale 1ns/10ps

module tb_buffer_manager;
    import bm_pkg::*;

    localparam int MAX_CYCLES = 4000;

    logic                 clk = 1'b0;
    logic                 rstn;
    logic                 ib_wr_en;
    logic [IFM_AW-1:0]    ib_wr_addr;
    ifm_word_t            ib_wr_data;
    logic                 fb_wr_en;
    logic [1:0]           fb_wr_bank;
    logic [FILTER_AW-1:0] fb_wr_addr;
    filter_word_t         fb_wr_data;
    logic [SIZE_W-1:0]    q_width;
    logic [CHN_W-1:0]     q_channel;
    logic                 c_csync_run;
    logic                 c_data_run;
    logic [SIZE_W-1:0]    c_row;
    logic [SIZE_W-1:0]    c_col;
    logic [CHN_W-1:0]     c_chn;
    logic                 c_is_first_row;
    logic                 c_is_last_row;
    logic                 c_is_last_col;
    logic                 c_is_last_chn;
    logic                 csync_done;
    logic                 fb_req;
    logic [FILTER_AW-1:0] fb_addr;
    logic                 fb_ready;
    ifm_word_t            ib_data0;
    ifm_word_t            ib_data1;
    ifm_word_t            ib_data2;
    filter_word_t         fb_data0;
    filter_word_t         fb_data1;
    filter_word_t         fb_data2;
    filter_word_t         fb_data3;

    // software copies of what was loaded
    ifm_word_t    ifm_model  [256];
    filter_word_t filt_model [4][64];
    int           cur_w;
    int           cur_c;
    int           cur_h;

    logic [31:0]  lcg_state = 32'hc904_2d14;
    int           err_cnt   = 0;
    int           check_cnt = 0;
    int           cycle_cnt = 0;
    // {run, row, col, chn} of the last three presented slots
    logic [24:0]  coord_q [$];

    buffer_manager uut (.*);

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected {above, current, below} with zero padding at top and bottom
    function automatic logic [3*IFM_DW-1:0] ref_window(input int row, input int col,
                                                       input int chn, input int height);
        int        stride;
        int        pos;
        ifm_word_t abv;
        ifm_word_t cur;
        ifm_word_t bel;
        stride = cur_w * cur_c;
        pos    = row * stride + col * cur_c + chn;
        abv    = '0;
        bel    = '0;
        cur    = ifm_model[pos];
        if (row != 0) begin
            abv = ifm_model[pos - stride];
        end
        if (row != height - 1) begin
            bel = ifm_model[pos + stride];
        end
        return {abv, cur, bel};
    endfunction

    task automatic check_value(input string what, input logic [95:0] got,
                               input logic [95:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0d ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle();
        c_data_run     <= 1'b0;
        c_row          <= '0;
        c_col          <= '0;
        c_chn          <= '0;
        c_is_first_row <= 1'b0;
        c_is_last_row  <= 1'b0;
        c_is_last_col  <= 1'b0;
        c_is_last_chn  <= 1'b0;
    endtask

    // ----------------------------------------
    // output compare 3 cycles behind the coordinate
    // ----------------------------------------
    always @(negedge clk) begin : compare_outputs
        logic [24:0]          ent;
        logic [3*IFM_DW-1:0]  exp;
        string                tag;
        if (!rstn) begin
            coord_q.delete();
        end else begin
            if (coord_q.size() == 3) begin
                ent = coord_q.pop_front();
                exp = '0;
                // idle slot expects all zero
                if (ent[24]) begin
                    exp = ref_window(ent[23:16], ent[15:8], ent[7:0], cur_h);
                end
                tag = $sformatf("run %0d row %0d col %0d chn %0d",
                                ent[24], ent[23:16], ent[15:8], ent[7:0]);
                check_value({"ib_data0 ", tag}, ib_data0, exp[3*IFM_DW-1:2*IFM_DW]);
                check_value({"ib_data1 ", tag}, ib_data1, exp[2*IFM_DW-1:IFM_DW]);
                check_value({"ib_data2 ", tag}, ib_data2, exp[IFM_DW-1:0]);
            end
            coord_q.push_back({c_data_run, c_row, c_col, c_chn});
        end
    end

    // ----------------------------------------
    // load and run tasks
    // ----------------------------------------
    task automatic load_ifm(input int words);
        for (int a = 0; a < words; a++) begin
            ifm_model[a] = lcg_next();
            @(posedge clk);
            ib_wr_en   <= 1'b1;
            ib_wr_addr <= IFM_AW'(a);
            ib_wr_data <= ifm_model[a];
        end
        @(posedge clk);
        ib_wr_en <= 1'b0;
    endtask

    // bank 3 goes last so its top word sets the ready flag
    task automatic load_filters(input int words);
        logic [31:0] hi;
        logic [31:0] mid;
        logic [31:0] lo;
        for (int b = 0; b < NUM_FB; b++) begin
            for (int a = 0; a < words; a++) begin
                hi  = lcg_next();
                mid = lcg_next();
                lo  = lcg_next();
                filt_model[b][a] = {hi[7:0], mid, lo};
                @(posedge clk);
                fb_wr_en   <= 1'b1;
                fb_wr_bank <= 2'(b);
                fb_wr_addr <= FILTER_AW'(a);
                fb_wr_data <= filt_model[b][a];
                // last word not sampled yet so done stays low
                @(negedge clk);
                check_value("csync_done during filter load", csync_done, 1'b0);
            end
        end
        @(posedge clk);
        fb_wr_en <= 1'b0;
    endtask

    task automatic wait_csync_done(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!csync_done && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!csync_done) begin
            err_cnt++;
            $display("csync_done never arrived within %0d cycles", limit);
        end
    endtask

    // random reads with data one cycle after the request and held after
    task automatic read_filters(input int count, input int words);
        logic [FILTER_AW-1:0] a;
        for (int i = 0; i < count; i++) begin
            a = FILTER_AW'(lcg_next() % words);
            @(posedge clk);
            fb_req  <= 1'b1;
            fb_addr <= a;
            @(posedge clk);
            fb_req  <= 1'b0;
            fb_addr <= '0;
            @(negedge clk);
            check_value($sformatf("fb_data0 addr %0d", a), fb_data0, filt_model[0][a]);
            check_value($sformatf("fb_data1 addr %0d", a), fb_data1, filt_model[1][a]);
            check_value($sformatf("fb_data2 addr %0d", a), fb_data2, filt_model[2][a]);
            check_value($sformatf("fb_data3 addr %0d", a), fb_data3, filt_model[3][a]);
            @(negedge clk);
            check_value($sformatf("fb_data3 hold addr %0d", a), fb_data3, filt_model[3][a]);
        end
    endtask

    // channel varies fastest and a gap follows every 7th slot
    task automatic stream_window(input int w, input int c, input int h);
        int idx;
        idx = 0;
        for (int r = 0; r < h; r++) begin
            for (int x = 0; x < w; x++) begin
                for (int ch = 0; ch < c; ch++) begin
                    @(posedge clk);
                    c_data_run     <= 1'b1;
                    c_row          <= SIZE_W'(r);
                    c_col          <= SIZE_W'(x);
                    c_chn          <= CHN_W'(ch);
                    c_is_first_row <= (r == 0);
                    c_is_last_row  <= (r == h - 1);
                    c_is_last_col  <= (x == w - 1);
                    c_is_last_chn  <= (ch == c - 1);
                    idx++;
                    if (idx % 7 == 0) begin
                        @(posedge clk);
                        drive_idle();
                    end
                end
            end
        end
        @(posedge clk);
        drive_idle();
        // drain the pipe
        repeat (5) @(posedge clk);
    endtask

    task automatic run_pass(input int w, input int c, input int h);
        @(posedge clk);
        q_width   <= SIZE_W'(w);
        q_channel <= CHN_W'(c);
        cur_w = w;
        cur_c = c;
        cur_h = h;
        load_ifm(w * c * h);
        // sync starts before the filters so the old ready flag must drop
        @(posedge clk);
        c_csync_run <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("fb_ready after csync start", fb_ready, 1'b0);
        repeat (w * c + 4) @(posedge clk);
        @(negedge clk);
        check_value("csync_done before filter load", csync_done, 1'b0);
        load_filters(4 * c);
        wait_csync_done(20);
        check_value("fb_ready after filter load", fb_ready, 1'b1);
        read_filters(6, 4 * c);
        stream_window(w, c, h);
        @(posedge clk);
        c_csync_run <= 1'b0;
        @(negedge clk);
        check_value("csync_done after sync end", csync_done, 1'b0);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        rstn        <= 1'b0;
        ib_wr_en    <= 1'b0;
        ib_wr_addr  <= '0;
        ib_wr_data  <= '0;
        fb_wr_en    <= 1'b0;
        fb_wr_bank  <= '0;
        fb_wr_addr  <= '0;
        fb_wr_data  <= '0;
        q_width     <= '0;
        q_channel   <= '0;
        c_csync_run <= 1'b0;
        fb_req      <= 1'b0;
        fb_addr     <= '0;
        drive_idle();
        cur_w = 1;
        cur_c = 1;
        cur_h = 1;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_value("csync_done after reset", csync_done, 1'b0);
        check_value("fb_ready after reset", fb_ready, 1'b0);
        check_value("ib_data0 after reset", ib_data0, '0);
        check_value("ib_data1 after reset", ib_data1, '0);
        check_value("ib_data2 after reset", ib_data2, '0);
        // pass 1 then pass 2 with a new shape and new data
        run_pass(4, 2, 4);
        run_pass(3, 3, 4);
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
bm_pkg.sv
dpram.sv
filter_bank.sv
row_prefill.sv
ifm_addr_gen.sv
row_window.sv
buffer_manager.sv
tb_buffer_manager.sv
